// File: ahb_matrix.f
+incdir+include
logic/ahb_matrix_pkg.sv
logic/ahb_matrix_input_stage.sv
logic/ahb_matrix_default_slave.sv
logic/ahb_matrix_decoder.sv
logic/ahb_matrix_output_stage.sv
logic/ahb_matrix.sv
sim/ahb_matrix_slave_bfm.sv
sim/ahb_matrix_props.sv
sim/ahb_matrix_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AHB matrix testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module ahb_matrix_tb -f ahb_matrix.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vahb_matrix_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
  exit 0
fi
exit 1

// File: sim/ahb_matrix_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_consts.svh"

module ahb_matrix_tb
  import ahb_matrix_pkg::*;
();

  localparam int CLK_NS = 8;

  logic               HCLK;
  logic               HRESETn;
  logic [`AHB_AW-1:0] haddr [2];    // Index 0 is s0
  htrans_e            htrans [2];
  logic               hwrite [2];
  logic [`AHB_DW-1:0] hwdata [2];
  logic               hreadyout_s0, hreadyout_s1;
  hresp_e             hresp_s0, hresp_s1;
  logic [`AHB_DW-1:0] hrdata_s0, hrdata_s1;
  logic               rdy [2];
  hresp_e             rsp [2];
  logic [`AHB_DW-1:0] rdat [2];
  logic               hsel_m0, hsel_m1, hwrite_m0, hwrite_m1;
  logic               hreadyout_m0, hreadyout_m1;
  logic [`AHB_AW-1:0] haddr_m0, haddr_m1;
  htrans_e            htrans_m0, htrans_m1;
  hresp_e             hresp_m0, hresp_m1;
  logic [`AHB_DW-1:0] hwdata_m0, hwdata_m1, hrdata_m0, hrdata_m1;

  // Stimulus table with one row per master and step
  int                 t_step [$];
  int                 t_mst [$];
  logic [`AHB_AW-1:0] t_addr [$];
  logic               t_wr [$];
  logic [`AHB_DW-1:0] t_data [$];
  logic [`AHB_DW-1:0] got_rd [64];
  hresp_e             got_rs [64];
  logic [`AHB_DW-1:0] shadow [logic [`AHB_AW-1:0]];   // Expected memory contents
  logic [`AHB_AW-1:0] m0_log [$];                     // Addresses accepted at m0
  int                 n_tests = 0;
  int                 n_fail = 0;

  assign rdy[0]  = hreadyout_s0;
  assign rdy[1]  = hreadyout_s1;
  assign rsp[0]  = hresp_s0;
  assign rsp[1]  = hresp_s1;
  assign rdat[0] = hrdata_s0;
  assign rdat[1] = hrdata_s1;

  // ------------------------------
  // DUT and slave models
  // ------------------------------
  ahb_matrix UUT
  (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .haddr_s0 (haddr[0]), .htrans_s0 (htrans[0]), .hwrite_s0 (hwrite[0]),
    .hwdata_s0 (hwdata[0]), .hready_s0 (hreadyout_s0),   // Single-master style tie
    .hreadyout_s0 (hreadyout_s0), .hresp_s0 (hresp_s0), .hrdata_s0 (hrdata_s0),
    .haddr_s1 (haddr[1]), .htrans_s1 (htrans[1]), .hwrite_s1 (hwrite[1]),
    .hwdata_s1 (hwdata[1]), .hready_s1 (hreadyout_s1),
    .hreadyout_s1 (hreadyout_s1), .hresp_s1 (hresp_s1), .hrdata_s1 (hrdata_s1),
    .hsel_m0 (hsel_m0), .haddr_m0 (haddr_m0), .htrans_m0 (htrans_m0),
    .hwrite_m0 (hwrite_m0), .hwdata_m0 (hwdata_m0),
    .hreadyout_m0 (hreadyout_m0), .hresp_m0 (hresp_m0), .hrdata_m0 (hrdata_m0),
    .hsel_m1 (hsel_m1), .haddr_m1 (haddr_m1), .htrans_m1 (htrans_m1),
    .hwrite_m1 (hwrite_m1), .hwdata_m1 (hwdata_m1),
    .hreadyout_m1 (hreadyout_m1), .hresp_m1 (hresp_m1), .hrdata_m1 (hrdata_m1)
  );

  ahb_matrix_slave_bfm #(.WAITS(0)) u_sram
  (
    .HCLK (HCLK), .HRESETn (HRESETn), .hsel (hsel_m0), .haddr (haddr_m0),
    .htrans (htrans_m0), .hwrite (hwrite_m0), .hwdata (hwdata_m0),
    .hreadyout (hreadyout_m0), .hresp (hresp_m0), .hrdata (hrdata_m0)
  );

  ahb_matrix_slave_bfm #(.WAITS(2)) u_periph
  (
    .HCLK (HCLK), .HRESETn (HRESETn), .hsel (hsel_m1), .haddr (haddr_m1),
    .htrans (htrans_m1), .hwrite (hwrite_m1), .hwdata (hwdata_m1),
    .hreadyout (hreadyout_m1), .hresp (hresp_m1), .hrdata (hrdata_m1)
  );

  bind ahb_matrix ahb_matrix_props u_props
  (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .hold_ready_s0 (hold_ready_s0), .hold_ready_s1 (hold_ready_s1),
    .active_s0 (active_s0), .active_s1 (active_s1),
    .held_addr_s0 (held_addr_s0), .held_addr_s1 (held_addr_s1),
    .act_m0_s0 (act_m0_s0), .act_m0_s1 (act_m0_s1),
    .act_m1_s0 (act_m1_s0), .act_m1_s1 (act_m1_s1),
    .hreadyout_s0 (hreadyout_s0), .hreadyout_s1 (hreadyout_s1),
    .hresp_s0 (hresp_s0), .hresp_s1 (hresp_s1),
    .hreadyout_m0 (hreadyout_m0), .hreadyout_m1 (hreadyout_m1),
    .hsel_m0 (hsel_m0), .hsel_m1 (hsel_m1),
    .haddr_m0 (haddr_m0), .haddr_m1 (haddr_m1)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #(CLK_NS / 2) HCLK = ~HCLK;
  end

  // Address about to be sampled by the SRAM port
  always @(negedge HCLK)
  begin
    if (hsel_m0 && (htrans_m0 == NONSEQ) && hreadyout_m0)
      m0_log.push_back(haddr_m0);
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  // Slave port from the address map (2 when unmapped)
  function automatic int port_of(input logic [`AHB_AW-1:0] a);
    if (a <= 32'h0000_FFFF)
      return 0;
    if ((a >= 32'h4000_0000) && (a <= 32'h4000_7FFF))
      return 1;
    return 2;
  endfunction

  task automatic add_row(input int step, input int m, input logic [`AHB_AW-1:0] a,
                         input logic w);
    t_step.push_back(step);
    t_mst.push_back(m);
    t_addr.push_back(a);
    t_wr.push_back(w);
    t_data.push_back(w ? $urandom : 32'h0);   // Random write data
  endtask

  task automatic build_table();
    add_row(0, 0, 32'h0000_0010, 1'b1);    // SRAM from s0
    add_row(1, 0, 32'h0000_0024, 1'b1);
    add_row(2, 0, 32'h0000_0010, 1'b0);
    add_row(3, 0, 32'h0000_0024, 1'b0);
    add_row(4, 1, 32'h4000_0100, 1'b1);    // Peripheral from s1 with wait states
    add_row(5, 1, 32'h4000_0100, 1'b0);
    add_row(6, 1, 32'h4000_7FFC, 1'b1);
    add_row(7, 1, 32'h4000_7FFC, 1'b0);
    add_row(8, 0, 32'h2000_0000, 1'b0);    // Unmapped
    add_row(9, 0, 32'h0000_8000, 1'b1);
    add_row(10, 0, 32'h0000_8000, 1'b0);
    add_row(11, 1, 32'h0001_0000, 1'b1);   // Just past SRAM window
    add_row(12, 0, 32'h0000_0040, 1'b1);   // Both on SRAM
    add_row(12, 1, 32'h0000_0080, 1'b1);
    add_row(13, 0, 32'h0000_0080, 1'b0);
    add_row(13, 1, 32'h0000_0040, 1'b0);
    add_row(14, 0, 32'h0000_00C0, 1'b1);   // Different ports at once
    add_row(14, 1, 32'h4000_0200, 1'b1);
    add_row(15, 0, 32'h4000_0200, 1'b0);
    add_row(15, 1, 32'h0000_00C0, 1'b0);
  endtask

  // One AHB transfer with address and data phase
  task automatic run_row(input int r);
    int m;
    m = t_mst[r];
    @(posedge HCLK);
    haddr[m]  <= t_addr[r];
    htrans[m] <= NONSEQ;
    hwrite[m] <= t_wr[r];
    @(negedge HCLK);
    while (!rdy[m])
      @(negedge HCLK);
    @(posedge HCLK);                       // Address accepted here
    htrans[m] <= IDLE;
    hwdata[m] <= t_data[r];
    @(negedge HCLK);
    while (!rdy[m])
      @(negedge HCLK);
    got_rd[r] = rdat[m];                   // Stable before completing edge
    got_rs[r] = rsp[m];
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp, inout logic ok);
    if (got !== exp)
    begin
      $display("ERR %s exp %08h got %08h", name, exp, got);
      ok = 1'b0;
    end
  endtask

  task automatic report_test(input string what, input logic ok);
    n_tests++;
    if (!ok)
      n_fail++;
    $display("Test %0d %s: %s", n_tests, what, ok ? "pass" : "FAIL");
  endtask

  task automatic check_row(input int r);
    int                 m;
    int                 p;
    logic               ok;
    logic [`AHB_DW-1:0] exp_rd;
    m      = t_mst[r];
    p      = port_of(t_addr[r]);
    ok     = 1'b1;
    exp_rd = '0;                           // Unmapped reads give zero
    if (!t_wr[r] && (p != 2))
      exp_rd = shadow[t_addr[r]];
    check_val($sformatf("hresp_s%0d", m), 32'(got_rs[r]), (p == 2) ? 32'h1 : 32'h0, ok);
    if (!t_wr[r])
      check_val($sformatf("hrdata_s%0d", m), got_rd[r], exp_rd, ok);
    if (t_wr[r] && (p != 2))
      shadow[t_addr[r]] = t_data[r];
    report_test($sformatf("s%0d %s %08h", m, t_wr[r] ? "write" : "read", t_addr[r]), ok);
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge HCLK);
    $display("Timeout after %0d cycles, a transfer never completed", cycles);
    $display("Some tests failed");
    $finish;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    int   i;
    logic pair;
    logic ok;
    void'($urandom(95));
    HRESETn = 1'b0;
    for (int m = 0; m < 2; m++)
    begin
      haddr[m]  = '0;
      htrans[m] = IDLE;
      hwrite[m] = 1'b0;
      hwdata[m] = '0;
    end
    build_table();
    fork
      watchdog(t_step.size() * 40 + 20);
    join_none
    repeat (5) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);
    ok = 1'b1;                             // Idle state after reset
    check_val("hsel_m0", 32'(hsel_m0), 32'h0, ok);
    check_val("hsel_m1", 32'(hsel_m1), 32'h0, ok);
    check_val("hreadyout_s0", 32'(hreadyout_s0), 32'h1, ok);
    check_val("hreadyout_s1", 32'(hreadyout_s1), 32'h1, ok);
    check_val("hresp_s0", 32'(hresp_s0), 32'h0, ok);
    check_val("hresp_s1", 32'(hresp_s1), 32'h0, ok);
    report_test("reset state", ok);
    i = 0;
    while (i < t_step.size())
    begin
      pair = (i + 1 < t_step.size()) && (t_step[i + 1] == t_step[i]);
      m0_log.delete();
      if (pair)
      begin
        fork
          run_row(i);
          run_row(i + 1);
        join
      end
      else
        run_row(i);
      check_row(i);
      if (pair)
        check_row(i + 1);
      // s0 must win a tie on the SRAM port
      if (pair && (port_of(t_addr[i]) == 0) && (port_of(t_addr[i + 1]) == 0))
      begin
        ok = 1'b1;
        if (m0_log.size() == 0)
        begin
          $display("No address reached the SRAM port in step %0d", t_step[i]);
          ok = 1'b0;
        end
        else
          check_val("haddr_m0", m0_log[0], t_addr[i], ok);
        report_test("s0 first at m0", ok);
      end
      i += pair ? 2 : 1;
    end
    repeat (2) @(posedge HCLK);
    $display("Summary: %0d tests, %0d failed, %0d assertion failures",
             n_tests, n_fail, UUT.u_props.fail_count);
    if ((n_fail == 0) && (UUT.u_props.fail_count == 0))
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/ahb_matrix_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_consts.svh"

module ahb_matrix_props
  import ahb_matrix_pkg::*;
(
  input logic               HCLK,
  input logic               HRESETn,
  input logic               hold_ready_s0,
  input logic               hold_ready_s1,
  input logic               active_s0,
  input logic               active_s1,
  input logic [`AHB_AW-1:0] held_addr_s0,
  input logic [`AHB_AW-1:0] held_addr_s1,
  input logic               act_m0_s0,
  input logic               act_m0_s1,
  input logic               act_m1_s0,
  input logic               act_m1_s1,
  input logic               hreadyout_s0,
  input logic               hreadyout_s1,
  input hresp_e             hresp_s0,
  input hresp_e             hresp_s1,
  input logic               hreadyout_m0,
  input logic               hreadyout_m1,
  input logic               hsel_m0,
  input logic               hsel_m1,
  input logic [`AHB_AW-1:0] haddr_m0,
  input logic [`AHB_AW-1:0] haddr_m1
);

  int fail_count = 0;   // Read back by the testbench

  // ------------------------------
  // Parked transfer reaches its slave port
  // ------------------------------
  hold_s0: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (!hold_ready_s0 && active_s0) |->
      ((hsel_m0 && (haddr_m0 == held_addr_s0)) || (hsel_m1 && (haddr_m1 == held_addr_s0))))
    else begin $error("s0 parked transfer lost"); fail_count++; end
  hold_s1: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (!hold_ready_s1 && active_s1) |->
      ((hsel_m0 && (haddr_m0 == held_addr_s1)) || (hsel_m1 && (haddr_m1 == held_addr_s1))))
    else begin $error("s1 parked transfer lost"); fail_count++; end

  // One owner per slave port
  onehot_m0: assert property (@(posedge HCLK) disable iff (!HRESETn) !(act_m0_s0 && act_m0_s1))
    else begin $error("m0 granted to both masters"); fail_count++; end
  onehot_m1: assert property (@(posedge HCLK) disable iff (!HRESETn) !(act_m1_s0 && act_m1_s1))
    else begin $error("m1 granted to both masters"); fail_count++; end

  // ERROR takes a low ready cycle then a high one
  err_s0: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (hresp_s0 == ERROR && !hreadyout_s0) |=> (hresp_s0 == ERROR && hreadyout_s0))
    else begin $error("s0 ERROR not two cycles"); fail_count++; end
  err_s1: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (hresp_s1 == ERROR && !hreadyout_s1) |=> (hresp_s1 == ERROR && hreadyout_s1))
    else begin $error("s1 ERROR not two cycles"); fail_count++; end

  // Grant frozen during slave wait states
  gnt_m0: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (!hreadyout_m0 ##1 !hreadyout_m0) |-> ($stable(hsel_m0) && $stable(haddr_m0)))
    else begin $error("m0 grant moved in wait state"); fail_count++; end
  gnt_m1: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (!hreadyout_m1 ##1 !hreadyout_m1) |-> ($stable(hsel_m1) && $stable(haddr_m1)))
    else begin $error("m1 grant moved in wait state"); fail_count++; end

endmodule

`default_nettype wire

// File: sim/ahb_matrix_slave_bfm.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_consts.svh"

module ahb_matrix_slave_bfm
  import ahb_matrix_pkg::*;
#(
  parameter int WAITS = 0   // Wait states per data phase
)
(
  input  logic               HCLK,
  input  logic               HRESETn,
  input  logic               hsel,
  input  logic [`AHB_AW-1:0] haddr,
  input  htrans_e            htrans,
  input  logic               hwrite,
  input  logic [`AHB_DW-1:0] hwdata,
  output logic               hreadyout,
  output hresp_e             hresp,
  output logic [`AHB_DW-1:0] hrdata
);

  logic [`AHB_DW-1:0] mem [0:255];   // Word store, low address bits only
  logic               dp_act;        // Data phase pending
  logic               dp_write;
  logic [7:0]         dp_idx;
  int                 wait_q;

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      dp_act <= 1'b0;
      wait_q <= 0;
    end
    else if (wait_q != 0)
      wait_q <= wait_q - 1;          // Stretch the data phase
    else
    begin
      if (dp_act && dp_write)
        mem[dp_idx] <= hwdata;       // Write lands at end of data phase
      dp_act   <= hsel && ((htrans == NONSEQ) || (htrans == SEQ));
      dp_write <= hwrite;
      dp_idx   <= haddr[9:2];
      if (hsel && ((htrans == NONSEQ) || (htrans == SEQ)))
        wait_q <= WAITS;
    end
  end

  assign hreadyout = (wait_q == 0);  // Registered, no path from inputs
  assign hresp     = OKAY;
  assign hrdata    = (dp_act && !dp_write) ? mem[dp_idx] : '0;

endmodule

`default_nettype wire

// File: logic/ahb_matrix.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_consts.svh"

module ahb_matrix
  import ahb_matrix_pkg::*;
(
  input  logic               HCLK,
  input  logic               HRESETn,
  // s0, CPU
  input  logic [`AHB_AW-1:0] haddr_s0,
  input  htrans_e            htrans_s0,
  input  logic               hwrite_s0,
  input  logic [`AHB_DW-1:0] hwdata_s0,
  input  logic               hready_s0,
  output logic               hreadyout_s0,
  output hresp_e             hresp_s0,
  output logic [`AHB_DW-1:0] hrdata_s0,
  // s1, DMA
  input  logic [`AHB_AW-1:0] haddr_s1,
  input  htrans_e            htrans_s1,
  input  logic               hwrite_s1,
  input  logic [`AHB_DW-1:0] hwdata_s1,
  input  logic               hready_s1,
  output logic               hreadyout_s1,
  output hresp_e             hresp_s1,
  output logic [`AHB_DW-1:0] hrdata_s1,
  // m0, SRAM window
  output logic               hsel_m0,
  output logic [`AHB_AW-1:0] haddr_m0,
  output htrans_e            htrans_m0,
  output logic               hwrite_m0,
  output logic [`AHB_DW-1:0] hwdata_m0,
  input  logic               hreadyout_m0,
  input  hresp_e             hresp_m0,
  input  logic [`AHB_DW-1:0] hrdata_m0,
  // m1, peripheral window
  output logic               hsel_m1,
  output logic [`AHB_AW-1:0] haddr_m1,
  output htrans_e            htrans_m1,
  output logic               hwrite_m1,
  output logic [`AHB_DW-1:0] hwdata_m1,
  input  logic               hreadyout_m1,
  input  hresp_e             hresp_m1,
  input  logic [`AHB_DW-1:0] hrdata_m1
);

  // Per master path
  logic [`AHB_AW-1:0] held_addr_s0, held_addr_s1;
  htrans_e            held_trans_s0, held_trans_s1;
  logic               held_write_s0, held_write_s1;
  logic               hold_ready_s0, hold_ready_s1;
  logic               sel_sram_s0, sel_sram_s1;
  logic               sel_periph_s0, sel_periph_s1;
  logic               active_s0, active_s1;        // Decoder back to input stage
  logic               act_m0_s0, act_m0_s1;        // From SRAM output stage
  logic               act_m1_s0, act_m1_s1;        // From peripheral output stage
  logic               dec_ready_s0, dec_ready_s1;
  hresp_e             dec_resp_s0, dec_resp_s1;

  // ------------------------------
  // s0 path
  // ------------------------------
  ahb_matrix_input_stage u_in_s0
  (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .haddr (haddr_s0), .htrans (htrans_s0), .hwrite (hwrite_s0),
    .hready (hready_s0), .active (active_s0),
    .held_addr (held_addr_s0), .held_trans (held_trans_s0),
    .held_write (held_write_s0), .hold_ready (hold_ready_s0)
  );

  ahb_matrix_decoder u_dec_s0
  (
    .HCLK (HCLK), .HRESETn (HRESETn), .hready (hready_s0),
    .held_addr (held_addr_s0), .held_trans (held_trans_s0),
    .active_sram (act_m0_s0), .active_periph (act_m1_s0),
    .ready_sram (hreadyout_m0), .resp_sram (hresp_m0), .rdata_sram (hrdata_m0),
    .ready_periph (hreadyout_m1), .resp_periph (hresp_m1), .rdata_periph (hrdata_m1),
    .sel_sram (sel_sram_s0), .sel_periph (sel_periph_s0), .active (active_s0),
    .hreadyout (dec_ready_s0), .hresp (dec_resp_s0), .hrdata (hrdata_s0)
  );

  // Parked transfer masks the shared port response
  assign hreadyout_s0 = hold_ready_s0 && dec_ready_s0;
  assign hresp_s0     = hold_ready_s0 ? dec_resp_s0 : OKAY;

  // ------------------------------
  // s1 path
  // ------------------------------
  ahb_matrix_input_stage u_in_s1
  (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .haddr (haddr_s1), .htrans (htrans_s1), .hwrite (hwrite_s1),
    .hready (hready_s1), .active (active_s1),
    .held_addr (held_addr_s1), .held_trans (held_trans_s1),
    .held_write (held_write_s1), .hold_ready (hold_ready_s1)
  );

  ahb_matrix_decoder u_dec_s1
  (
    .HCLK (HCLK), .HRESETn (HRESETn), .hready (hready_s1),
    .held_addr (held_addr_s1), .held_trans (held_trans_s1),
    .active_sram (act_m0_s1), .active_periph (act_m1_s1),
    .ready_sram (hreadyout_m0), .resp_sram (hresp_m0), .rdata_sram (hrdata_m0),
    .ready_periph (hreadyout_m1), .resp_periph (hresp_m1), .rdata_periph (hrdata_m1),
    .sel_sram (sel_sram_s1), .sel_periph (sel_periph_s1), .active (active_s1),
    .hreadyout (dec_ready_s1), .hresp (dec_resp_s1), .hrdata (hrdata_s1)
  );

  assign hreadyout_s1 = hold_ready_s1 && dec_ready_s1;
  assign hresp_s1     = hold_ready_s1 ? dec_resp_s1 : OKAY;

  // ------------------------------
  // Slave ports
  // ------------------------------
  ahb_matrix_output_stage u_out_m0
  (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .sel_s0 (sel_sram_s0), .sel_s1 (sel_sram_s1),
    .addr_s0 (held_addr_s0), .trans_s0 (held_trans_s0),
    .write_s0 (held_write_s0), .wdata_s0 (hwdata_s0),
    .addr_s1 (held_addr_s1), .trans_s1 (held_trans_s1),
    .write_s1 (held_write_s1), .wdata_s1 (hwdata_s1),
    .hreadyout_m (hreadyout_m0),
    .hsel_m (hsel_m0), .haddr_m (haddr_m0), .htrans_m (htrans_m0),
    .hwrite_m (hwrite_m0), .hwdata_m (hwdata_m0),
    .active_s0 (act_m0_s0), .active_s1 (act_m0_s1)
  );

  ahb_matrix_output_stage u_out_m1
  (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .sel_s0 (sel_periph_s0), .sel_s1 (sel_periph_s1),
    .addr_s0 (held_addr_s0), .trans_s0 (held_trans_s0),
    .write_s0 (held_write_s0), .wdata_s0 (hwdata_s0),
    .addr_s1 (held_addr_s1), .trans_s1 (held_trans_s1),
    .write_s1 (held_write_s1), .wdata_s1 (hwdata_s1),
    .hreadyout_m (hreadyout_m1),
    .hsel_m (hsel_m1), .haddr_m (haddr_m1), .htrans_m (htrans_m1),
    .hwrite_m (hwrite_m1), .hwdata_m (hwdata_m1),
    .active_s0 (act_m1_s0), .active_s1 (act_m1_s1)
  );

endmodule

`default_nettype wire

// File: logic/ahb_matrix_output_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_consts.svh"

module ahb_matrix_output_stage
  import ahb_matrix_pkg::*;
(
  input  logic               HCLK,
  input  logic               HRESETn,
  input  logic               sel_s0,
  input  logic               sel_s1,
  input  logic [`AHB_AW-1:0] addr_s0,
  input  htrans_e            trans_s0,
  input  logic               write_s0,
  input  logic [`AHB_DW-1:0] wdata_s0,
  input  logic [`AHB_AW-1:0] addr_s1,
  input  htrans_e            trans_s1,
  input  logic               write_s1,
  input  logic [`AHB_DW-1:0] wdata_s1,
  input  logic               hreadyout_m,    // Slave ready, also this port's HREADY
  output logic               hsel_m,
  output logic [`AHB_AW-1:0] haddr_m,
  output htrans_e            htrans_m,
  output logic               hwrite_m,
  output logic [`AHB_DW-1:0] hwdata_m,
  output logic               active_s0,
  output logic               active_s1
);

  logic req_s0;       // Master wants this port
  logic req_s1;
  logic data_s1_q;    // Owner of the beat in data phase, 1 for s1
  logic in_burst;     // That owner still streaming beats
  logic gnt_s1;       // Address phase owner this cycle

  assign req_s0 = sel_s0 && (trans_s0 != IDLE);
  assign req_s1 = sel_s1 && (trans_s1 != IDLE);

  assign in_burst = data_s1_q ? (req_s1 && ((trans_s1 == BUSY) || (trans_s1 == SEQ)))
                              : (req_s0 && ((trans_s0 == BUSY) || (trans_s0 == SEQ)));

  // ------------------------------
  // Fixed priority arbiter
  // ------------------------------
  always_comb
  begin
    gnt_s1 = data_s1_q;           // Stay with last owner
    if (hreadyout_m && !in_burst)
    begin
      if (req_s0)
        gnt_s1 = 1'b0;            // s0 first
      else if (req_s1)
        gnt_s1 = 1'b1;
    end
  end

  // Moves only when the slave samples an address
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_s1_q <= 1'b0;
    else if (hreadyout_m)
      data_s1_q <= gnt_s1;
  end

  // ------------------------------
  // Slave side muxes
  // ------------------------------
  assign hsel_m   = gnt_s1 ? req_s1 : req_s0;
  assign haddr_m  = gnt_s1 ? addr_s1 : addr_s0;
  assign hwrite_m = gnt_s1 ? write_s1 : write_s0;
  assign hwdata_m = data_s1_q ? wdata_s1 : wdata_s0;   // Follows data phase

  always_comb
  begin
    if (!hsel_m)
      htrans_m = IDLE;
    else
      htrans_m = gnt_s1 ? trans_s1 : trans_s0;
  end

  // Address goes out only on a ready edge
  assign active_s0 = hreadyout_m && !gnt_s1;
  assign active_s1 = hreadyout_m && gnt_s1;

endmodule

`default_nettype wire

// File: logic/ahb_matrix_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_consts.svh"

module ahb_matrix_decoder
  import ahb_matrix_pkg::*;
(
  input  logic               HCLK,
  input  logic               HRESETn,
  input  logic               hready,         // Local HREADY of this master
  input  logic [`AHB_AW-1:0] held_addr,
  input  htrans_e            held_trans,
  input  logic               active_sram,
  input  logic               active_periph,
  input  logic               ready_sram,
  input  hresp_e             resp_sram,
  input  logic [`AHB_DW-1:0] rdata_sram,
  input  logic               ready_periph,
  input  hresp_e             resp_periph,
  input  logic [`AHB_DW-1:0] rdata_periph,
  output logic               sel_sram,
  output logic               sel_periph,
  output logic               active,
  output logic               hreadyout,
  output hresp_e             hresp,
  output logic [`AHB_DW-1:0] hrdata
);

  logic [`AHB_AW-1:`DEC_LSB] dec_addr;   // 1 KB granule
  logic                      in_sram;
  logic                      in_periph;
  logic                      xfer_act;   // NONSEQ or SEQ
  port_sel_e                 addr_port;
  port_sel_e                 data_port_q;
  logic                      sel_dft;
  logic                      dft_ready;
  hresp_e                    dft_resp;

  // ------------------------------
  // Address phase
  // ------------------------------
  assign dec_addr  = held_addr[`AHB_AW-1:`DEC_LSB];
  assign in_sram   = (dec_addr >= `SRAM_LO) && (dec_addr <= `SRAM_HI);
  assign in_periph = (dec_addr >= `PERIPH_LO) && (dec_addr <= `PERIPH_HI);
  assign xfer_act  = (held_trans == NONSEQ) || (held_trans == SEQ);

  always_comb
  begin
    if ((held_trans == IDLE) && (data_port_q != PORT_NONE))
      addr_port = data_port_q;     // Idle keeps last port
    else if (in_sram)
      addr_port = PORT_SRAM;
    else if (in_periph)
      addr_port = PORT_PERIPH;
    else
      addr_port = PORT_DEFAULT;    // Unmapped
  end

  assign sel_sram   = (addr_port == PORT_SRAM);
  assign sel_periph = (addr_port == PORT_PERIPH);
  assign sel_dft    = (addr_port == PORT_DEFAULT);

  // Default slave is local, always free
  always_comb
  begin
    case (addr_port)
      PORT_SRAM   : active = active_sram;
      PORT_PERIPH : active = active_periph;
      default     : active = 1'b1;
    endcase
  end

  ahb_matrix_default_slave u_default_slave
  (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hsel      (sel_dft),
    .htrans    (held_trans),
    .hready    (hready),
    .hreadyout (dft_ready),
    .hresp     (dft_resp)
  );

  // ------------------------------
  // Data phase
  // ------------------------------
  // Also loads when the input stage parks the transfer
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_port_q <= PORT_NONE;
    else if (hready)
      data_port_q <= xfer_act ? addr_port : PORT_NONE;
  end

  always_comb
  begin
    case (data_port_q)
      PORT_SRAM :
      begin
        hreadyout = ready_sram;
        hresp     = resp_sram;
        hrdata    = rdata_sram;
      end
      PORT_PERIPH :
      begin
        hreadyout = ready_periph;
        hresp     = resp_periph;
        hrdata    = rdata_periph;
      end
      PORT_DEFAULT :
      begin
        hreadyout = dft_ready;
        hresp     = dft_resp;
        hrdata    = '0;            // No read data on error
      end
      default :
      begin
        hreadyout = 1'b1;          // Idle data phase
        hresp     = OKAY;
        hrdata    = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/ahb_matrix_default_slave.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_matrix_default_slave
  import ahb_matrix_pkg::*;
(
  input  logic    HCLK,
  input  logic    HRESETn,
  input  logic    hsel,
  input  htrans_e htrans,
  input  logic    hready,
  output logic    hreadyout,
  output hresp_e  hresp
);

  // Two error states make up the AHB two-cycle ERROR
  typedef enum logic [1:0]
  {
    DS_OKAY,      // Zero-wait OKAY
    DS_ERR_WAIT,  // First ERROR cycle, HREADYOUT low
    DS_ERR_LAST   // Second ERROR cycle, HREADYOUT high
  } ds_state_e;

  ds_state_e state_q;
  ds_state_e state_d;
  logic      req;      // Active transfer sampled here

  assign req = hsel && hready && ((htrans == NONSEQ) || (htrans == SEQ));

  always_comb
  begin
    case (state_q)
      DS_ERR_WAIT : state_d = DS_ERR_LAST;
      default     : state_d = req ? DS_ERR_WAIT : DS_OKAY;  // New transfer may follow
    endcase
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      state_q <= DS_OKAY;
    else
      state_q <= state_d;
  end

  assign hreadyout = (state_q != DS_ERR_WAIT);
  assign hresp     = (state_q == DS_OKAY) ? OKAY : ERROR;

endmodule

`default_nettype wire

// File: logic/ahb_matrix_input_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_consts.svh"

module ahb_matrix_input_stage
  import ahb_matrix_pkg::*;
(
  input  logic               HCLK,
  input  logic               HRESETn,
  input  logic [`AHB_AW-1:0] haddr,
  input  htrans_e            htrans,
  input  logic               hwrite,
  input  logic               hready,      // Master's own HREADY
  input  logic               active,      // Target port takes the address this cycle
  output logic [`AHB_AW-1:0] held_addr,
  output htrans_e            held_trans,
  output logic               held_write,
  output logic               hold_ready   // Low while a transfer is parked
);

  logic               pend_q;    // Holding register full
  logic [`AHB_AW-1:0] addr_q;
  htrans_e            trans_q;
  logic               write_q;
  logic               live_req;  // Master offers a real transfer
  logic               park;      // Accepted from master, port not free

  assign live_req = hready && ((htrans == NONSEQ) || (htrans == SEQ));
  assign park     = live_req && !active && !pend_q;

  // ------------------------------
  // Holding register
  // ------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_q <= 1'b0;
    else if (park)
      pend_q <= 1'b1;
    else if (pend_q && active)
      pend_q <= 1'b0;             // Port sampled the held copy
  end

  always_ff @(posedge HCLK)
  begin
    if (park)
    begin
      addr_q  <= haddr;
      trans_q <= htrans;
      write_q <= hwrite;
    end
  end

  // ------------------------------
  // Address phase towards decoder
  // ------------------------------
  always_comb
  begin
    if (pend_q)
    begin
      held_addr  = addr_q;        // Parked copy wins
      held_trans = trans_q;
      held_write = write_q;
    end
    else
    begin
      held_addr  = haddr;
      // Transfer only visible once master's data phase is done
      held_trans = hready ? htrans : IDLE;
      held_write = hwrite;
    end
  end

  // Stretches the master's data phase until the parked transfer goes out
  assign hold_ready = !pend_q;

endmodule

`default_nettype wire

// File: logic/ahb_matrix_pkg.sv
`default_nettype none

package ahb_matrix_pkg;

  // AHB transfer type on HTRANS
  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Slave response, AHB-Lite keeps only the low bit
  typedef enum logic
  {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  // Decoder target, for both the address and the data phase
  typedef enum logic [1:0]
  {
    PORT_SRAM    = 2'd0,
    PORT_PERIPH  = 2'd1,
    PORT_DEFAULT = 2'd2,  // Local error slave
    PORT_NONE    = 2'd3   // No data phase pending
  } port_sel_e;

endpackage

`default_nettype wire

// File: include/ahb_matrix_consts.svh
`ifndef AHB_MATRIX_CONSTS_SVH
`define AHB_MATRIX_CONSTS_SVH

// Bus widths
`define AHB_AW 32
`define AHB_DW 32

// Decode compares HADDR[31:10], so window bounds are in 1 KB units
`define DEC_LSB 10

// SRAM window, 0x0000_0000 to 0x0000_FFFF
`define SRAM_LO 22'h000000
`define SRAM_HI 22'h00003F

// Peripheral window, 0x4000_0000 to 0x4000_7FFF
`define PERIPH_LO 22'h100000
`define PERIPH_HI 22'h10001F

`endif
